// ==== Makefile ====
VERILATOR := verilator
VFLAGS := --binary --assert -j 0
TOP := proc_tb
FILELIST := all.f
BUILD_DIR := obj_dir
SIM := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))
PASS_TEXT := PASS: all tests

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== all.f ====
common/proc_pkg.sv
common/control_bus.sv
source/control_pipeline.sv
source/fetch.sv
source/decode.sv
source/hazard_detection_unit.sv
source/scalar_execute.sv
source/writeback.sv
source/proc.sv
verif/proc_assert.sv
verif/proc_tb.sv

// ==== common/control_bus.sv ====
`default_nettype none

interface control_bus;
    import proc_pkg::*;

    logic valid;
    alu_op_t alu_op;
    logic use_imm;
    logic reg_wr_en;
    reg_addr_t write_register;
    reg_addr_t read_register1;  // Zero when the instruction has no first source.
    reg_addr_t read_register2;  // Zero when the instruction has no second source.
    logic store_immediate;
    logic imm_hl;  // High half when set.
    logic invert;
    logic halt;

    modport source (
        output valid, alu_op, use_imm, reg_wr_en, write_register,
        output read_register1, read_register2,
        output store_immediate, imm_hl, invert, halt
    );

    modport sink (
        input valid, alu_op, use_imm, reg_wr_en, write_register,
        input read_register1, read_register2,
        input store_immediate, imm_hl, invert, halt
    );

endinterface

`default_nettype wire

// ==== common/proc_pkg.sv ====
`default_nettype none

package proc_pkg;

    parameter int IMEM_DEPTH = 64;
    parameter int NUM_REGS = 32;

    typedef logic [35:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [35:0] pc_t;  // Counts instruction words.
    typedef logic [4:0] reg_addr_t;
    typedef logic [17:0] imm_t;

    typedef enum logic [3:0] {
        ADD  = 4'h0,
        SUB  = 4'h1,
        AND  = 4'h2,
        XOR  = 4'h3,
        ADDI = 4'h4,
        LIH  = 4'h5,
        LIL  = 4'h6,
        NOT  = 4'h7,
        BEQZ = 4'h8,
        HALT = 4'h9,
        NOP  = 4'hf
    } opcode_t;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_AND = 2'd2,
        ALU_XOR = 2'd3
    } alu_op_t;

endpackage

`default_nettype wire

// ==== source/control_pipeline.sv ====
`default_nettype none

module control_pipeline (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic stall,
    input wire logic bubble,
    control_bus.sink control_d,
    control_bus.source control_q
);
    import proc_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            control_q.valid <= 1'b0;
            control_q.alu_op <= ALU_ADD;
            control_q.use_imm <= 1'b0;
            control_q.reg_wr_en <= 1'b0;
            control_q.write_register <= '0;
            control_q.read_register1 <= '0;
            control_q.read_register2 <= '0;
            control_q.store_immediate <= 1'b0;
            control_q.imm_hl <= 1'b0;
            control_q.invert <= 1'b0;
            control_q.halt <= 1'b0;
        end else if (!stall) begin
            control_q.valid <= control_d.valid && !bubble;
            control_q.alu_op <= control_d.alu_op;
            control_q.use_imm <= control_d.use_imm;
            control_q.reg_wr_en <= control_d.reg_wr_en && !bubble;
            control_q.write_register <= control_d.write_register;
            control_q.read_register1 <= control_d.read_register1;
            control_q.read_register2 <= control_d.read_register2;
            control_q.store_immediate <= control_d.store_immediate;
            control_q.imm_hl <= control_d.imm_hl;
            control_q.invert <= control_d.invert;
            control_q.halt <= control_d.halt && !bubble;
        end
    end

endmodule

`default_nettype wire

// ==== source/decode.sv ====
`default_nettype none

module decode (
    input wire logic clk,
    input wire logic rst_n,
    input wire proc_pkg::inst_t inst,
    input wire proc_pkg::pc_t pc,
    input wire logic inst_valid,
    input wire logic wr_en,
    input wire proc_pkg::reg_addr_t write_register,
    input wire proc_pkg::word_t write_data,
    control_bus.source control,
    output proc_pkg::word_t sdata1,
    output proc_pkg::word_t sdata2,
    output proc_pkg::imm_t immediate,
    output logic branch_taken,
    output proc_pkg::pc_t branch_pc
);
    import proc_pkg::*;

    opcode_t opcode;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t read1;
    reg_addr_t read2;
    word_t regs [NUM_REGS];

    assign opcode = opcode_t'(inst[31:28]);
    assign rd = inst[24:20];
    assign rs1 = inst[19:15];
    assign rs2 = inst[14:10];
    assign immediate = inst[17:0];

    // Register 0 is never written, so it keeps its reset value of zero.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && write_register != '0) begin
            regs[write_register] <= write_data;
        end
    end

    always_comb begin
        read1 = rs1;
        read2 = '0;
        control.alu_op = ALU_ADD;
        control.use_imm = 1'b0;
        control.reg_wr_en = 1'b1;
        control.store_immediate = 1'b0;
        control.imm_hl = 1'b0;
        control.invert = 1'b0;
        control.halt = 1'b0;
        case (opcode)
            ADD: read2 = rs2;
            SUB: begin
                control.alu_op = ALU_SUB;
                read2 = rs2;
            end
            AND: begin
                control.alu_op = ALU_AND;
                read2 = rs2;
            end
            XOR: begin
                control.alu_op = ALU_XOR;
                read2 = rs2;
            end
            ADDI: control.use_imm = 1'b1;
            LIH: begin
                control.store_immediate = 1'b1;
                control.imm_hl = 1'b1;
                read1 = rd;  // Old value supplies the low half.
            end
            LIL: begin
                control.store_immediate = 1'b1;
                read1 = rd;
            end
            NOT: control.invert = 1'b1;
            BEQZ: control.reg_wr_en = 1'b0;
            HALT: begin
                read1 = '0;
                control.reg_wr_en = 1'b0;
                control.halt = 1'b1;
            end
            default: begin
                read1 = '0;
                control.reg_wr_en = 1'b0;
            end
        endcase
    end

    assign control.valid = inst_valid;
    assign control.write_register = rd;
    assign control.read_register1 = read1;
    assign control.read_register2 = read2;

    assign sdata1 = regs[read1];
    assign sdata2 = regs[read2];

    assign branch_taken = inst_valid && opcode == BEQZ && sdata1 == '0;
    assign branch_pc = pc + pc_t'(immediate);

endmodule

`default_nettype wire

// ==== source/fetch.sv ====
`default_nettype none

module fetch #(
    parameter int imem_depth = proc_pkg::IMEM_DEPTH
) (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic start,
    input wire logic stall,
    input wire logic halt,
    input wire logic branch_taken,
    input wire proc_pkg::pc_t branch_pc,
    input wire logic imem_we,
    input wire proc_pkg::pc_t imem_addr,
    input wire proc_pkg::inst_t imem_data,
    output proc_pkg::inst_t inst,
    output proc_pkg::pc_t pc,
    output logic running,
    output logic fetch_valid
);
    import proc_pkg::*;

    localparam int addr_w = $clog2(imem_depth);

    typedef enum logic {
        IDLE,
        RUN
    } run_state_t;

    run_state_t state;
    inst_t imem [imem_depth];

    always_ff @(posedge clk) begin
        if (imem_we && state == IDLE) begin  // Loading is ignored while the core runs.
            imem[imem_addr[addr_w-1:0]] <= imem_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            pc <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= RUN;
                        pc <= '0;
                    end
                end
                RUN: begin
                    if (halt) begin
                        state <= IDLE;
                    end else if (!stall) begin
                        pc <= branch_taken ? branch_pc : pc + pc_t'(1);  // Stall wins over a branch.
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign inst = imem[pc[addr_w-1:0]];
    assign running = (state == RUN);
    assign fetch_valid = running && !branch_taken && !halt;

endmodule

`default_nettype wire

// ==== source/hazard_detection_unit.sv ====
`default_nettype none

module hazard_detection_unit (
    control_bus.sink decode_control,
    control_bus.sink execute_control,
    control_bus.sink writeback_control,
    output logic stall
);

    logic execute_hit;
    logic writeback_hit;

    // A nonzero destination can only match a source that is really read.
    assign execute_hit = execute_control.valid && execute_control.reg_wr_en &&
        execute_control.write_register != '0 &&
        (decode_control.read_register1 == execute_control.write_register ||
         decode_control.read_register2 == execute_control.write_register);

    assign writeback_hit = writeback_control.valid && writeback_control.reg_wr_en &&
        writeback_control.write_register != '0 &&
        (decode_control.read_register1 == writeback_control.write_register ||
         decode_control.read_register2 == writeback_control.write_register);

    assign stall = decode_control.valid && (execute_hit || writeback_hit);

endmodule

`default_nettype wire

// ==== source/proc.sv ====
`default_nettype none

module proc #(
    parameter int imem_depth = proc_pkg::IMEM_DEPTH
) (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic start,
    input wire logic imem_we,
    input wire proc_pkg::pc_t imem_addr,
    input wire proc_pkg::inst_t imem_data,
    output logic done,
    output logic wb_valid,
    output proc_pkg::reg_addr_t wb_addr,
    output proc_pkg::word_t wb_data
);
    import proc_pkg::*;

    control_bus decode_control();
    control_bus execute_control();
    control_bus writeback_control();

    inst_t inst_f;
    inst_t inst_d;
    pc_t pc_f;
    pc_t pc_d;
    pc_t branch_pc;
    logic fetch_valid;
    logic valid_d;
    logic running;
    logic stall;
    logic branch_taken;
    logic halt_d;
    logic halt_done;
    word_t sdata1_d;
    word_t sdata2_d;
    word_t sdata_out_e;
    word_t sdata1_e;
    imm_t immediate_d;
    imm_t immediate_e;
    logic reg_wr_en_w;
    reg_addr_t write_register_w;
    word_t write_data_w;

    assign halt_d = decode_control.valid && decode_control.halt;

    fetch #(.imem_depth(imem_depth)) u_fetch (
        .clk(clk), .rst_n(rst_n), .start(start), .stall(stall), .halt(halt_d),
        .branch_taken(branch_taken), .branch_pc(branch_pc),
        .imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
        .inst(inst_f), .pc(pc_f), .running(running), .fetch_valid(fetch_valid)
    );

    // The instruction behind a taken branch is dropped here.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_d <= 1'b0;
        end else if (!stall) begin
            valid_d <= fetch_valid && !branch_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            inst_d <= inst_f;
            pc_d <= pc_f;
        end
    end

    decode u_decode (
        .clk(clk), .rst_n(rst_n), .inst(inst_d), .pc(pc_d), .inst_valid(valid_d),
        .wr_en(reg_wr_en_w), .write_register(write_register_w), .write_data(write_data_w),
        .control(decode_control), .sdata1(sdata1_d), .sdata2(sdata2_d),
        .immediate(immediate_d), .branch_taken(branch_taken), .branch_pc(branch_pc)
    );

    hazard_detection_unit u_hdu (
        .decode_control(decode_control), .execute_control(execute_control),
        .writeback_control(writeback_control), .stall(stall)
    );

    control_pipeline u_ctrl_de (
        .clk(clk), .rst_n(rst_n), .stall(1'b0), .bubble(stall),
        .control_d(decode_control), .control_q(execute_control)
    );

    control_pipeline u_ctrl_ew (
        .clk(clk), .rst_n(rst_n), .stall(1'b0), .bubble(1'b0),
        .control_d(execute_control), .control_q(writeback_control)
    );

    scalar_execute u_execute (
        .clk(clk), .rst_n(rst_n), .bubble(stall), .sdata1_d(sdata1_d), .sdata2_d(sdata2_d),
        .immediate_d(immediate_d), .control(execute_control),
        .sdata_out(sdata_out_e), .sdata1(sdata1_e), .immediate(immediate_e)
    );

    writeback u_writeback (
        .clk(clk), .rst_n(rst_n), .sdata_out_e(sdata_out_e), .sdata1_e(sdata1_e),
        .immediate_e(immediate_e), .control(writeback_control),
        .wr_en(reg_wr_en_w), .write_register(write_register_w),
        .write_data(write_data_w), .halt_done(halt_done)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else if (start && !running) begin
            done <= 1'b0;
        end else if (halt_done) begin
            done <= 1'b1;  // Set as the HALT leaves writeback.
        end
    end

    assign wb_valid = reg_wr_en_w;
    assign wb_addr = write_register_w;
    assign wb_data = write_data_w;

endmodule

`default_nettype wire

// ==== source/scalar_execute.sv ====
`default_nettype none

module scalar_execute (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic bubble,
    input wire proc_pkg::word_t sdata1_d,
    input wire proc_pkg::word_t sdata2_d,
    input wire proc_pkg::imm_t immediate_d,
    control_bus.sink control,
    output proc_pkg::word_t sdata_out,
    output proc_pkg::word_t sdata1,
    output proc_pkg::imm_t immediate
);
    import proc_pkg::*;

    word_t sdata2;
    word_t operand_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sdata1 <= '0;
            sdata2 <= '0;
            immediate <= '0;
        end else if (bubble) begin
            sdata1 <= '0;  // Keeps the ALU quiet behind a stall bubble.
            sdata2 <= '0;
            immediate <= '0;
        end else begin
            sdata1 <= sdata1_d;
            sdata2 <= sdata2_d;
            immediate <= immediate_d;
        end
    end

    assign operand_b = control.use_imm ? word_t'(immediate) : sdata2;

    always_comb begin
        case (control.alu_op)
            ALU_ADD: sdata_out = sdata1 + operand_b;
            ALU_SUB: sdata_out = sdata1 - operand_b;
            ALU_AND: sdata_out = sdata1 & operand_b;
            ALU_XOR: sdata_out = sdata1 ^ operand_b;
            default: sdata_out = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/writeback.sv ====
`default_nettype none

module writeback (
    input wire logic clk,
    input wire logic rst_n,
    input wire proc_pkg::word_t sdata_out_e,
    input wire proc_pkg::word_t sdata1_e,
    input wire proc_pkg::imm_t immediate_e,
    control_bus.sink control,
    output logic wr_en,
    output proc_pkg::reg_addr_t write_register,
    output proc_pkg::word_t write_data,
    output logic halt_done
);
    import proc_pkg::*;

    word_t sdata_out_w;
    word_t sdata1_w;
    imm_t immediate_w;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sdata_out_w <= '0;
            sdata1_w <= '0;
            immediate_w <= '0;
        end else begin
            sdata_out_w <= sdata_out_e;
            sdata1_w <= sdata1_e;
            immediate_w <= immediate_e;
        end
    end

    always_comb begin
        if (control.store_immediate) begin
            write_data = control.imm_hl ? {immediate_w, sdata1_w[17:0]}
                                        : {sdata1_w[35:18], immediate_w};
        end else if (control.invert) begin
            write_data = ~sdata1_w;
        end else begin
            write_data = sdata_out_w;
        end
    end

    assign write_register = control.write_register;
    assign wr_en = control.valid && control.reg_wr_en && control.write_register != '0;
    assign halt_done = control.valid && control.halt;

endmodule

`default_nettype wire

// ==== verif/proc_assert.sv ====
`default_nettype none

module proc_assert (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic start,
    input wire logic imem_we,
    input wire logic running,
    input wire logic done,
    input wire logic wb_valid
);

    logic started;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            started <= 1'b0;
        end else if (start) begin
            started <= 1'b1;
        end
    end

    no_commit_while_done: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> !wb_valid)
        else $error("wb_valid fired while done was high.");

    no_commit_before_start: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !wb_valid)
        else $error("wb_valid fired before the first start.");

    done_held_until_start: assert property (@(posedge clk) disable iff (!rst_n)
        done && !start |=> done)
        else $error("done fell without a start.");

    start_while_halted: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !running)
        else $error("start pulsed while the core was running.");

    load_while_halted: assert property (@(posedge clk) disable iff (!rst_n)
        imem_we |-> !running)
        else $error("Instruction memory written while the core was running.");

endmodule

bind proc proc_assert u_proc_assert (
    .clk(clk), .rst_n(rst_n), .start(start), .imem_we(imem_we), .running(running),
    .done(done), .wb_valid(wb_valid)
);

`default_nettype wire

// ==== verif/proc_tb.sv ====
`default_nettype none

module proc_tb;
    import proc_pkg::*;

    localparam int clk_period = 100;
    localparam int drive_delay = 10;
    localparam int reset_cycles = 16;

    logic clk;
    logic rst_n;
    logic start;
    logic imem_we;
    pc_t imem_addr;
    inst_t imem_data;
    logic done;
    logic wb_valid;
    reg_addr_t wb_addr;
    word_t wb_data;

    inst_t prog_a[$];
    inst_t prog_b[$];
    inst_t program_words[$];
    reg_addr_t exp_addr[$];
    word_t exp_data[$];
    word_t model_regs [32];
    logic started;
    int error_count;
    int cycle_count;
    int cycle_limit;

    proc #(.imem_depth(IMEM_DEPTH)) u_proc (
        .clk(clk), .rst_n(rst_n), .start(start), .imem_we(imem_we), .imem_addr(imem_addr),
        .imem_data(imem_data), .done(done), .wb_valid(wb_valid), .wb_addr(wb_addr),
        .wb_data(wb_data)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic report_failure();
        $display("FAIL: see errors above");
        $fatal(1, "Run stopped at time %0t.", $time);
    endtask

    task automatic check_failed(input string msg);
        error_count++;
        $display("%s", msg);
        report_failure();
    endtask

    function automatic inst_t reg_format(opcode_t op, reg_addr_t rd, reg_addr_t rs1,
                                         reg_addr_t rs2);
        return {op, 3'b000, rd, rs1, rs2, 10'd0};
    endfunction

    // The top three immediate bits are the low bits of the first source field.
    function automatic inst_t imm_format(opcode_t op, reg_addr_t rd, reg_addr_t rs1,
                                         logic [14:0] low);
        return {op, 3'b000, rd, rs1, low};
    endfunction

    function automatic inst_t half_load(opcode_t op, reg_addr_t rd, imm_t value);
        return {op, 3'b000, rd, 2'b00, value};
    endfunction

    task automatic build_programs();
        prog_a.push_back(half_load(LIH, 5'd1, imm_t'($urandom)));
        prog_a.push_back(half_load(LIL, 5'd1, imm_t'($urandom)));
        prog_a.push_back(reg_format(NOT, 5'd2, 5'd1, 5'd0));
        prog_a.push_back(half_load(LIH, 5'd3, imm_t'($urandom)));
        prog_a.push_back(half_load(LIL, 5'd3, imm_t'($urandom)));
        prog_a.push_back(reg_format(ADD, 5'd4, 5'd1, 5'd3));
        prog_a.push_back(reg_format(SUB, 5'd5, 5'd1, 5'd3));
        prog_a.push_back(reg_format(AND, 5'd6, 5'd1, 5'd3));
        prog_a.push_back(reg_format(XOR, 5'd7, 5'd1, 5'd3));
        prog_a.push_back(imm_format(ADDI, 5'd9, 5'd1, 15'($urandom)));
        prog_a.push_back(reg_format(ADD, 5'd10, 5'd4, 5'd5));
        prog_a.push_back(reg_format(SUB, 5'd11, 5'd10, 5'd2));
        prog_a.push_back(reg_format(XOR, 5'd12, 5'd11, 5'd10));
        prog_a.push_back(imm_format(ADDI, 5'd13, 5'd12, 15'($urandom)));
        prog_a.push_back(imm_format(BEQZ, 5'd0, 5'd8, 15'd2));  // R8 is zero, so this skips.
        prog_a.push_back(half_load(LIL, 5'd14, imm_t'($urandom)));
        prog_a.push_back(half_load(LIL, 5'd16, imm_t'($urandom) | imm_t'(1)));
        prog_a.push_back(imm_format(BEQZ, 5'd0, 5'd16, 15'd3));
        prog_a.push_back(reg_format(ADD, 5'd15, 5'd13, 5'd9));
        prog_a.push_back(imm_format(BEQZ, 5'd0, 5'd0, 15'd2));
        prog_a.push_back(reg_format(NOT, 5'd17, 5'd1, 5'd0));
        prog_a.push_back(reg_format(HALT, 5'd0, 5'd0, 5'd0));
        prog_a.push_back(reg_format(ADD, 5'd18, 5'd1, 5'd3));
        prog_b.push_back(half_load(LIL, 5'd20, imm_t'($urandom)));
        prog_b.push_back(half_load(LIH, 5'd20, imm_t'($urandom)));
        prog_b.push_back(imm_format(ADDI, 5'd21, 5'd20, 15'($urandom)));
        prog_b.push_back(reg_format(ADD, 5'd22, 5'd21, 5'd20));
        prog_b.push_back(reg_format(NOT, 5'd23, 5'd22, 5'd0));
        prog_b.push_back(reg_format(AND, 5'd24, 5'd23, 5'd21));
        prog_b.push_back(reg_format(ADD, 5'd0, 5'd22, 5'd23));
        prog_b.push_back(reg_format(SUB, 5'd25, 5'd0, 5'd24));
        prog_b.push_back(reg_format(XOR, 5'd8, 5'd7, 5'd7));
        prog_b.push_back(imm_format(BEQZ, 5'd0, 5'd8, 15'd2));
        prog_b.push_back(reg_format(ADD, 5'd26, 5'd1, 5'd3));
        prog_b.push_back(imm_format(BEQZ, 5'd0, 5'd24, 15'd2));
        prog_b.push_back(half_load(LIL, 5'd27, imm_t'($urandom)));
        prog_b.push_back(reg_format(HALT, 5'd0, 5'd0, 5'd0));
    endtask

    // Runs the program in order and queues every commit it should produce.
    task automatic run_model();
        int pc;
        inst_t inst;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        imm_t imm;
        word_t result;
        logic writes;
        logic taken;
        logic halted;
        pc = 0;
        halted = 1'b0;
        while (!halted) begin
            if (pc >= program_words.size()) begin
                check_failed($sformatf("Reference model ran past the program end at %0d.", pc));
            end
            inst = program_words[pc];
            rd = inst[24:20];
            rs1 = inst[19:15];
            rs2 = inst[14:10];
            imm = inst[17:0];
            result = '0;
            writes = 1'b1;
            taken = 1'b0;
            case (opcode_t'(inst[31:28]))
                ADD: result = model_regs[rs1] + model_regs[rs2];
                SUB: result = model_regs[rs1] - model_regs[rs2];
                AND: result = model_regs[rs1] & model_regs[rs2];
                XOR: result = model_regs[rs1] ^ model_regs[rs2];
                ADDI: result = model_regs[rs1] + word_t'(imm);
                LIH: result = {imm, model_regs[rd][17:0]};
                LIL: result = {model_regs[rd][35:18], imm};
                NOT: result = ~model_regs[rs1];
                BEQZ: begin
                    writes = 1'b0;
                    taken = (model_regs[rs1] == '0);
                end
                HALT: begin
                    writes = 1'b0;
                    halted = 1'b1;
                end
                default: writes = 1'b0;
            endcase
            if (writes && rd != '0) begin
                model_regs[rd] = result;
                exp_addr.push_back(rd);
                exp_data.push_back(result);
            end
            pc = taken ? pc + int'(imm) : pc + 1;
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < program_words.size(); i++) begin
            @(posedge clk);
            #drive_delay;
            imem_we = 1'b1;
            imem_addr = pc_t'(i);
            imem_data = program_words[i];
        end
        @(posedge clk);
        #drive_delay;
        imem_we = 1'b0;
    endtask

    task automatic run_program();
        load_program();
        run_model();
        @(posedge clk);
        #drive_delay;
        start = 1'b1;
        started = 1'b1;
        @(posedge clk);
        #drive_delay;
        start = 1'b0;
        @(negedge clk);
        while (!done) begin
            @(negedge clk);
        end
        assert (exp_addr.size() == 0)
        else check_failed($sformatf("done rose with %0d commits missing.", exp_addr.size()));
    endtask

    always @(negedge clk) begin
        if (rst_n && !started) begin
            assert (!done)
            else check_failed($sformatf("ERROR at time %0t: done is %b, expected 0",
                                        $time, done));
            assert (!wb_valid)
            else check_failed($sformatf("ERROR at time %0t: wb_valid is %b, expected 0",
                                        $time, wb_valid));
        end
        if (rst_n && wb_valid) begin
            assert (exp_addr.size() != 0)
            else check_failed($sformatf("Unexpected commit to register %0d at %0t.",
                                        wb_addr, $time));
            assert (wb_addr == exp_addr[0])
            else check_failed($sformatf("ERROR at time %0t: wb_addr is %0d, expected %0d",
                                        $time, wb_addr, exp_addr[0]));
            assert (wb_data == exp_data[0])
            else check_failed($sformatf("ERROR at time %0t: wb_data is %h, expected %h",
                                        $time, wb_data, exp_data[0]));
            exp_addr.delete(0);
            exp_data.delete(0);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
            report_failure();
        end
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        imem_we = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        started = 1'b0;
        error_count = 0;
        cycle_count = 0;
        void'($urandom(32'ha6e5));
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        build_programs();
        cycle_limit = 8 * (prog_a.size() + prog_b.size()) + 200;
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;
        repeat (4) @(posedge clk);  // Idle window before the first start.
        program_words = prog_a;
        run_program();
        program_words = prog_b;  // Registers carry over from the first program.
        run_program();
        if (error_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            report_failure();
        end
    end

endmodule

`default_nettype wire
